/* logic/tlb_defines.svh */
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// Buffer geometry
`define TLB_SETS            8
`define TLB_OFFSETS         4   // Row pairs per set and bank
`define TLB_BANKS           2
`define TLB_PAGE_BITS       12

// Address and config bus widths
`define TLB_VA_WIDTH        32
`define TLB_PA_WIDTH        40
`define TLB_CFG_DATA_WIDTH  64
`define TLB_CFG_ADDR_WIDTH  32

`define TLB_SET_BITS        $clog2(`TLB_SETS)
`define TLB_OFF_BITS        $clog2(`TLB_OFFSETS)
`define TLB_BANK_BITS       $clog2(`TLB_BANKS)
`define TLB_ROW_BITS        (`TLB_SET_BITS + 1 + `TLB_OFF_BITS)
`define TLB_PA_IDX_BITS     (`TLB_ROW_BITS + `TLB_BANK_BITS)

// Virtual entry flags in config data
`define TLB_ENT_VALID       0
`define TLB_ENT_READ        1
`define TLB_ENT_WRITE       2

`endif

/* logic/tlb_addr_pkg.sv */
`default_nettype none

`include "tlb_defines.svh"

package tlb_addr_pkg;

   ////////////////////
   // Addresses

   typedef logic [`TLB_VA_WIDTH-1:0] va_t;
   typedef logic [`TLB_PA_WIDTH-1:0] pa_t;

   typedef logic [`TLB_VA_WIDTH-`TLB_PAGE_BITS-1:0] va_page_t;
   typedef logic [`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0] pa_page_t;

   ////////////////////
   // RAM indices

   typedef logic [`TLB_SET_BITS-1:0]    set_idx_t;
   typedef logic [`TLB_OFF_BITS-1:0]    off_idx_t;
   typedef logic [`TLB_ROW_BITS-1:0]    row_idx_t;   // {set, port half, offset}
   typedef logic [`TLB_PA_IDX_BITS-1:0] pa_idx_t;    // {row, bank}

   // Config write bus
   typedef logic [`TLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
   typedef logic [`TLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

`default_nettype wire

/* logic/tlb_ctrl_pkg.sv */
`default_nettype none

package tlb_ctrl_pkg;

   // Request type, as on rw_type_i
   typedef enum logic {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_e;

   typedef enum logic [1:0] {
      S_IDLE, S_SEARCH, S_DONE
   } search_state_e;

   typedef enum logic [1:0] {
      O_IDLE, O_SEND, O_SENT
   } out_state_e;

endpackage

`default_nettype wire

/* logic/tlb_search_if.sv */
`default_nettype none

`include "tlb_defines.svh"

interface tlb_search_if;
   import tlb_addr_pkg::*;
   import tlb_ctrl_pkg::*;

   // Request side, from the controller
   va_page_t page;
   access_e  access;
   row_idx_t row0;      // Port half 0
   row_idx_t row1;      // Port half 1
   logic     look;      // Rows valid this cycle

   // One slot per bank
   logic     [`TLB_BANKS-1:0] bank_hit;
   logic     [`TLB_BANKS-1:0] bank_prot;
   row_idx_t [`TLB_BANKS-1:0] bank_row;

   logic     found;     // Any bank matched

   modport ctrl  (output page, access, row0, row1, look, input found);
   modport bank  (input page, access, row0, row1, look,
                  output bank_hit, bank_prot, bank_row);
   modport merge (input bank_hit, bank_prot, bank_row, page, output found);

endinterface

`default_nettype wire

/* logic/tlb_va_bank.sv */
`default_nettype none

`include "tlb_defines.svh"

module tlb_va_bank #(
   parameter int unsigned BANK_ID = 0
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_ni,
   input  wire logic                   cfg_we_i,
   input  wire tlb_addr_pkg::cfg_addr_t cfg_waddr_i,
   input  wire tlb_addr_pkg::cfg_data_t cfg_wdata_i,
   tlb_search_if.bank                  srch
);
   import tlb_addr_pkg::*;
   import tlb_ctrl_pkg::*;

   localparam int ROWS  = 2**`TLB_ROW_BITS;
   localparam int ENT_W = $bits(va_page_t) + 2;   // {page, w, r}
   localparam logic [`TLB_BANK_BITS-1:0] BANK_SEL = BANK_ID[`TLB_BANK_BITS-1:0];

   logic             ram_we;
   row_idx_t         wrow;
   logic [ENT_W-1:0] wentry;

   logic [ENT_W-1:0] va_ram [ROWS];
   logic [ROWS-1:0]  valid_q;

   logic [ENT_W-1:0] rd0_q, rd1_q;
   logic             v0_q, v1_q;
   row_idx_t         row0_q, row1_q;
   logic             look_q;

   logic [1:0]       chk0, chk1;   // {match, allowed}
   logic             match0, match1;

   function automatic logic [1:0] check_entry(logic v, logic [ENT_W-1:0] ent,
                                              va_page_t page, access_e acc);
      logic match;
      logic allow;
      match = v && (ent[ENT_W-1:2] == page);
      allow = (acc == ACC_WRITE) ? ent[1] : ent[0];
      return {match, allow};
   endfunction

   ////////////////////
   // Config write decode

   assign ram_we = cfg_we_i && !cfg_waddr_i[`TLB_PA_IDX_BITS]
                   && (cfg_waddr_i[`TLB_BANK_BITS-1:0] == BANK_SEL);
   assign wrow   = cfg_waddr_i[`TLB_PA_IDX_BITS-1:`TLB_BANK_BITS];
   assign wentry = {cfg_wdata_i[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS],
                    cfg_wdata_i[`TLB_ENT_WRITE], cfg_wdata_i[`TLB_ENT_READ]};

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         valid_q <= '0;
      end else if (ram_we) begin
         valid_q[wrow] <= cfg_wdata_i[`TLB_ENT_VALID];
      end
   end

   always_ff @(posedge clk_i) begin
      if (ram_we) begin
         va_ram[wrow] <= wentry;
      end
   end

   ////////////////////
   // Two read ports

   always_ff @(posedge clk_i) begin
      if (srch.look) begin
         rd0_q  <= va_ram[srch.row0];
         rd1_q  <= va_ram[srch.row1];
         v0_q   <= valid_q[srch.row0];
         v1_q   <= valid_q[srch.row1];
         row0_q <= srch.row0;
         row1_q <= srch.row1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         look_q <= 1'b0;
      end else begin
         look_q <= srch.look;    // Read data valid next cycle
      end
   end

   ////////////////////
   // Compare, half 0 wins

   assign chk0   = check_entry(v0_q, rd0_q, srch.page, srch.access);
   assign chk1   = check_entry(v1_q, rd1_q, srch.page, srch.access);
   assign match0 = look_q && chk0[1];
   assign match1 = look_q && chk1[1];

   assign srch.bank_hit[BANK_ID]  = match0 ? chk0[0] : (match1 && chk1[0]);
   assign srch.bank_prot[BANK_ID] = match0 ? !chk0[0] : (match1 && !chk1[0]);
   assign srch.bank_row[BANK_ID]  = match0 ? row0_q : row1_q;

   a_hit_prot_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(srch.bank_hit[BANK_ID] && srch.bank_prot[BANK_ID]));

endmodule

`default_nettype wire

/* logic/tlb_search_ctrl.sv */
`default_nettype none

`include "tlb_defines.svh"

module tlb_search_ctrl (
   input  wire logic                  clk_i,
   input  wire logic                  rst_ni,
   input  wire logic                  l1_miss_i,
   input  wire tlb_addr_pkg::va_t     in_addr_i,
   input  wire tlb_ctrl_pkg::access_e rw_type_i,
   input  wire logic                  result_i,      // Any result pulse
   input  wire logic                  trans_sent_i,
   input  wire logic                  hit_done_i,    // Hit pulse
   tlb_search_if.ctrl                 srch,
   output logic                       busy_o,
   output logic                       last_o
);
   import tlb_addr_pkg::*;
   import tlb_ctrl_pkg::*;

   search_state_e state_q, state_d;

   va_t      addr_q;
   access_e  acc_q;
   set_idx_t set_w;
   off_idx_t off_q;
   logic     last_q;
   logic     hit_wait_q;   // Hit sent, waiting on trans_sent_i
   logic     busy_q;

   ////////////////////
   // FSM

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         S_IDLE:   if (l1_miss_i) state_d = S_SEARCH;
         S_SEARCH: if (srch.found || last_q) state_d = S_DONE;   // Early stop on first match
         S_DONE: begin
            if ((result_i && !hit_done_i) || (hit_wait_q && trans_sent_i)) begin
               state_d = S_IDLE;
            end
         end
         default:  state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_wait_q <= 1'b0;
      end else if (hit_done_i) begin
         hit_wait_q <= 1'b1;
      end else if (trans_sent_i) begin
         hit_wait_q <= 1'b0;
      end
   end

   ////////////////////
   // Request capture

   always_ff @(posedge clk_i) begin
      if (l1_miss_i) begin
         addr_q <= in_addr_i;
         acc_q  <= rw_type_i;
      end
   end

   assign set_w = addr_q[`TLB_PAGE_BITS+`TLB_SET_BITS-1:`TLB_PAGE_BITS];

   // Offset stepping, one row pair per cycle
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         off_q  <= '0;
         last_q <= 1'b0;
      end else begin
         if (l1_miss_i) begin
            off_q <= '0;
         end else if (srch.look) begin
            off_q <= off_q + 1'b1;
         end
         last_q <= srch.look && (off_q == off_idx_t'(`TLB_OFFSETS-1));
      end
   end

   assign srch.page   = addr_q[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
   assign srch.access = acc_q;
   assign srch.row0   = {set_w, 1'b0, off_q};
   assign srch.row1   = {set_w, 1'b1, off_q};
   assign srch.look   = (state_q == S_SEARCH) && !last_q && !srch.found;

   // Busy from the miss until the FSM has been idle a cycle
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         busy_q <= 1'b0;
      end else begin
         busy_q <= (state_q != S_IDLE) || l1_miss_i;
      end
   end

   assign busy_o = busy_q;
   assign last_o = last_q;

   a_miss_in_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
      l1_miss_i |-> (state_q == S_IDLE));

endmodule

`default_nettype wire

/* logic/tlb_result.sv */
`default_nettype none

`include "tlb_defines.svh"

module tlb_result (
   input  wire logic                    clk_i,
   input  wire logic                    rst_ni,
   input  wire logic                    cfg_we_i,
   input  wire tlb_addr_pkg::cfg_addr_t cfg_waddr_i,
   input  wire tlb_addr_pkg::cfg_data_t cfg_wdata_i,
   tlb_search_if.merge                  srch,
   input  wire logic                    last_i,
   input  wire logic                    l1_miss_i,
   input  wire tlb_addr_pkg::va_t       in_addr_i,
   output logic                         hit_o,
   output logic                         miss_o,
   output logic                         prot_o,
   output tlb_addr_pkg::pa_t            out_addr_o
);
   import tlb_addr_pkg::*;
   import tlb_ctrl_pkg::*;

   localparam int PA_ROWS = 2**`TLB_PA_IDX_BITS;

   out_state_e out_q, out_d;

   logic                      kind_hit_q, kind_hit_d;
   logic                      kind_prot_q, kind_prot_d;
   logic [`TLB_BANK_BITS-1:0] sel;
   logic                      pa_re;
   logic                      pa_we;
   pa_idx_t                   pa_raddr;
   pa_page_t                  pa_ram [PA_ROWS];
   pa_page_t                  pa_q;
   va_t                       addr_q;

   ////////////////////
   // Bank merge

   assign srch.found = (|srch.bank_hit) || (|srch.bank_prot);

   // Lowest bank with a result
   always_comb begin
      sel = '0;
      for (int i = `TLB_BANKS-1; i >= 0; i--) begin
         if (srch.bank_hit[i] || srch.bank_prot[i]) begin
            sel = i[`TLB_BANK_BITS-1:0];
         end
      end
   end

   assign pa_raddr = {srch.bank_row[sel], sel};

   ////////////////////
   // Output FSM

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         out_q       <= O_IDLE;
         kind_hit_q  <= 1'b0;
         kind_prot_q <= 1'b0;
      end else begin
         out_q       <= out_d;
         kind_hit_q  <= kind_hit_d;
         kind_prot_q <= kind_prot_d;
      end
   end

   always_comb begin
      out_d       = out_q;
      kind_hit_d  = kind_hit_q;
      kind_prot_d = kind_prot_q;
      pa_re       = 1'b0;
      unique case (out_q)
         O_IDLE: begin
            if (srch.found) begin
               out_d       = O_SEND;
               kind_hit_d  = srch.bank_hit[sel];
               kind_prot_d = srch.bank_prot[sel];
               pa_re       = srch.bank_hit[sel];   // Data lands with the hit pulse
            end else if (last_i) begin
               out_d       = O_SEND;                // Nothing matched
               kind_hit_d  = 1'b0;
               kind_prot_d = 1'b0;
            end
         end
         O_SEND:  out_d = O_SENT;
         O_SENT:  if (l1_miss_i) out_d = O_IDLE;
         default: out_d = O_IDLE;
      endcase
   end

   assign hit_o  = (out_q == O_SEND) && kind_hit_q;
   assign prot_o = (out_q == O_SEND) && kind_prot_q;
   assign miss_o = (out_q == O_SEND) && !kind_hit_q && !kind_prot_q;

   ////////////////////
   // Physical page RAM

   assign pa_we = cfg_we_i && cfg_waddr_i[`TLB_PA_IDX_BITS];

   always_ff @(posedge clk_i) begin
      if (pa_we) begin
         pa_ram[cfg_waddr_i[`TLB_PA_IDX_BITS-1:0]] <=
            cfg_wdata_i[`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (pa_re) begin
         pa_q <= pa_ram[pa_raddr];   // Held until the next hit
      end
   end

   // In-page bits of the request
   always_ff @(posedge clk_i) begin
      if (l1_miss_i) begin
         addr_q <= in_addr_i;
      end
   end

   assign out_addr_o = {pa_q, addr_q[`TLB_PAGE_BITS-1:0]};

   a_result_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({hit_o, miss_o, prot_o}));

endmodule

`default_nettype wire

/* logic/tlb_l2.sv */
`default_nettype none

`include "tlb_defines.svh"

module tlb_l2 (
   input  wire logic                    clk_i,
   input  wire logic                    rst_ni,
   input  wire tlb_addr_pkg::va_t       in_addr_i,
   input  wire tlb_ctrl_pkg::access_e   rw_type_i,
   input  wire logic                    l1_miss_i,
   input  wire logic                    cfg_we_i,
   input  wire tlb_addr_pkg::cfg_addr_t cfg_waddr_i,
   input  wire tlb_addr_pkg::cfg_data_t cfg_wdata_i,
   input  wire logic                    l2_trans_sent_i,
   output logic                         hit_l2_o,
   output logic                         miss_l2_o,
   output logic                         prot_l2_o,
   output logic                         l2_busy_o,
   output tlb_addr_pkg::pa_t            out_addr_o
);

   tlb_search_if srch ();

   logic result_pulse;
   logic last_read;    // Final offset results present

   assign result_pulse = hit_l2_o || miss_l2_o || prot_l2_o;

   tlb_search_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .l1_miss_i    (l1_miss_i),
      .in_addr_i    (in_addr_i),
      .rw_type_i    (rw_type_i),
      .result_i     (result_pulse),
      .trans_sent_i (l2_trans_sent_i),
      .hit_done_i   (hit_l2_o),
      .srch         (srch.ctrl),
      .busy_o       (l2_busy_o),
      .last_o       (last_read)
   );

   ////////////////////
   // Banks searched in parallel

   for (genvar b = 0; b < `TLB_BANKS; b++) begin : g_bank
      tlb_va_bank #(
         .BANK_ID (b)
      ) u_bank (
         .clk_i       (clk_i),
         .rst_ni      (rst_ni),
         .cfg_we_i    (cfg_we_i),
         .cfg_waddr_i (cfg_waddr_i),
         .cfg_wdata_i (cfg_wdata_i),
         .srch        (srch.bank)
      );
   end

   tlb_result u_result (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cfg_we_i    (cfg_we_i),
      .cfg_waddr_i (cfg_waddr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .srch        (srch.merge),
      .last_i      (last_read),
      .l1_miss_i   (l1_miss_i),
      .in_addr_i   (in_addr_i),
      .hit_o       (hit_l2_o),
      .miss_o      (miss_l2_o),
      .prot_o      (prot_l2_o),
      .out_addr_o  (out_addr_o)
   );

endmodule

`default_nettype wire

/* sim/tlb_l2_tb_tasks.svh */
////////////////////
// Failure and compare

task automatic fail_stop(string why);
   $display("%s", why);
   $display("TEST FAIL");
   $fatal(1, "Stopped at the first error");
endtask

task automatic check_pa(string name, pa_t got, pa_t exp);
   if (got !== exp) begin
      fail_stop($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
   end
endtask

task automatic check_flag(string name, logic got, logic exp);
   if (got !== exp) begin
      fail_stop($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
   end
endtask

////////////////////
// Config writes

task automatic write_va(bank_t b, row_idx_t r);
   @(negedge clk_i);
   cfg_we    = 1'b1;
   cfg_waddr = '0;                                 // Bit 7 low, virtual RAMs
   cfg_waddr[`TLB_PA_IDX_BITS-1:0] = {r, b};
   cfg_wdata = '0;
   cfg_wdata[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS] = m_page[b][r];
   cfg_wdata[2] = m_wr[b][r];
   cfg_wdata[1] = m_rd[b][r];
   cfg_wdata[0] = m_valid[b][r];
   @(negedge clk_i);
   cfg_we = 1'b0;
endtask

task automatic write_pa(pa_idx_t pi);
   @(negedge clk_i);
   cfg_we    = 1'b1;
   cfg_waddr = '0;
   cfg_waddr[`TLB_PA_IDX_BITS]     = 1'b1;
   cfg_waddr[`TLB_PA_IDX_BITS-1:0] = pi;
   cfg_wdata = '0;
   cfg_wdata[$bits(pa_page_t)-1:0] = m_pa[pi];
   @(negedge clk_i);
   cfg_we = 1'b0;
endtask

////////////////////
// Lookup

// Busy must drop within 2 cycles of the end of a request
task automatic wait_idle();
   int cnt;
   cnt = 1;
   while (l2_busy) begin
      if (cnt >= WAIT_MAX) begin
         fail_stop("l2_busy_o stayed high for 50 cycles after the request ended");
      end
      @(negedge clk_i);
      cnt++;
   end
   if (cnt > 2) begin
      fail_stop($sformatf("l2_busy_o took %0d cycles to fall, only 2 allowed", cnt));
   end
endtask

task automatic run_request(va_t addr, access_e acc, int exp_kind, pa_t exp_pa);
   int cnt;
   int hold;
   @(negedge clk_i);
   check_flag("l2_busy_o", l2_busy, 1'b0);
   in_addr = addr;
   rw_type = acc;
   l1_miss = 1'b1;
   @(negedge clk_i);
   l1_miss = 1'b0;
   req_cnt++;
   cnt = 0;
   while (!(hit_l2 || miss_l2 || prot_l2)) begin
      check_flag("l2_busy_o", l2_busy, 1'b1);
      cnt++;
      if (cnt > WAIT_MAX) begin
         fail_stop("no result pulse within 50 cycles of l1_miss_i");
      end
      @(negedge clk_i);
   end
   check_flag("hit_l2_o", hit_l2, exp_kind == EXP_HIT);
   check_flag("miss_l2_o", miss_l2, exp_kind == EXP_MISS);
   check_flag("prot_l2_o", prot_l2, exp_kind == EXP_PROT);
   if (exp_kind == EXP_HIT) begin
      check_pa("out_addr_o", out_addr, exp_pa);
      hold = 1 + int'(take_bits(2));
      repeat (hold) begin                       // Stays busy until the send
         @(negedge clk_i);
         check_flag("l2_busy_o", l2_busy, 1'b1);
         check_pa("out_addr_o", out_addr, exp_pa);
      end
      trans_sent = 1'b1;
      @(negedge clk_i);
      trans_sent = 1'b0;
   end else begin
      @(negedge clk_i);
   end
   wait_idle();
endtask

/* sim/tlb_l2_tb.sv */
`default_nettype none

`include "tlb_defines.svh"

module tlb_l2_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import tlb_addr_pkg::*;
   import tlb_ctrl_pkg::*;

   localparam int ROWS     = 2**`TLB_ROW_BITS;
   localparam int PA_ROWS  = 2**`TLB_PA_IDX_BITS;
   localparam int SET_ROWS = 2*`TLB_OFFSETS;    // Rows of one set in one bank
   localparam int NUM_REQ  = 300;
   localparam int WAIT_MAX = 50;

   localparam int EXP_HIT  = 0;
   localparam int EXP_MISS = 1;
   localparam int EXP_PROT = 2;

   typedef logic [`TLB_BANK_BITS-1:0] bank_t;
   typedef logic [$bits(va_page_t)-`TLB_SET_BITS-1:0] page_hi_t;
   typedef logic [`TLB_PAGE_BITS-1:0] in_page_t;

   logic      clk_i;
   logic      rst_ni;
   va_t       in_addr;
   access_e   rw_type;
   logic      l1_miss;
   logic      cfg_we;
   cfg_addr_t cfg_waddr;
   cfg_data_t cfg_wdata;
   logic      trans_sent;
   logic      hit_l2;
   logic      miss_l2;
   logic      prot_l2;
   logic      l2_busy;
   pa_t       out_addr;

   // Reference model of both RAMs
   va_page_t m_page  [`TLB_BANKS][ROWS];
   logic     m_valid [`TLB_BANKS][ROWS];
   logic     m_rd    [`TLB_BANKS][ROWS];
   logic     m_wr    [`TLB_BANKS][ROWS];
   pa_page_t m_pa    [PA_ROWS];

   logic [31:0] lfsr_q;
   int          req_cnt;

   tlb_l2 dut0 (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .in_addr_i       (in_addr),
      .rw_type_i       (rw_type),
      .l1_miss_i       (l1_miss),
      .cfg_we_i        (cfg_we),
      .cfg_waddr_i     (cfg_waddr),
      .cfg_wdata_i     (cfg_wdata),
      .l2_trans_sent_i (trans_sent),
      .hit_l2_o        (hit_l2),
      .miss_l2_o       (miss_l2),
      .prot_l2_o       (prot_l2),
      .l2_busy_o       (l2_busy),
      .out_addr_o      (out_addr)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   ////////////////////
   // Random source

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

`include "tlb_l2_tb_tasks.svh"

   ////////////////////
   // Model upkeep

   function automatic logic page_used(set_idx_t s, va_page_t pg);
      row_idx_t r;
      for (int b = 0; b < `TLB_BANKS; b++) begin
         for (int i = 0; i < SET_ROWS; i++) begin
            r = row_idx_t'(int'(s) * SET_ROWS + i);
            if (m_page[b][r] == pg) begin
               return 1'b1;
            end
         end
      end
      return 1'b0;
   endfunction

   // Set bits sit at the bottom of the page, so a page stays in its set
   function automatic va_page_t new_page(set_idx_t s);
      va_page_t pg;
      do begin
         pg = {page_hi_t'(take_bits($bits(page_hi_t))), s};
      end while (page_used(s, pg));
      return pg;
   endfunction

   task automatic randomize_entry(bank_t b, row_idx_t r);
      set_idx_t s;
      s             = set_idx_t'(r >> (`TLB_ROW_BITS - `TLB_SET_BITS));
      m_page[b][r]  = new_page(s);
      m_valid[b][r] = (take_bits(2) != 32'd0);   // Mostly valid
      m_rd[b][r]    = (take_bits(1) != 32'd0);
      m_wr[b][r]    = (take_bits(1) != 32'd0);
      write_va(b, r);
   endtask

   task automatic fill_tables();
      for (int s = 0; s < `TLB_SETS; s++) begin
         for (int b = 0; b < `TLB_BANKS; b++) begin
            for (int i = 0; i < SET_ROWS; i++) begin
               randomize_entry(bank_t'(b), row_idx_t'(s * SET_ROWS + i));
            end
         end
      end
      for (int p = 0; p < PA_ROWS; p++) begin
         m_pa[p] = pa_page_t'(take_bits($bits(pa_page_t)));
         write_pa(pa_idx_t'(p));
      end
   endtask

   ////////////////////
   // Stimulus

   task automatic random_request();
      set_idx_t s;
      bank_t    b;
      row_idx_t r;
      pa_idx_t  pi;
      va_page_t pg;
      in_page_t low;
      access_e  acc;
      int       kind;
      s   = set_idx_t'(take_bits(`TLB_SET_BITS));
      b   = bank_t'(take_bits(`TLB_BANK_BITS));
      r   = row_idx_t'(int'(s) * SET_ROWS + int'(take_bits(`TLB_ROW_BITS - `TLB_SET_BITS)));
      pi  = {r, b};
      acc = (take_bits(1) == 32'd1) ? ACC_WRITE : ACC_READ;
      low = in_page_t'(take_bits(`TLB_PAGE_BITS));
      if (take_bits(3) == 32'd0) begin   // Occasional rewrite before the lookup
         randomize_entry(b, r);
         m_pa[pi] = pa_page_t'(take_bits($bits(pa_page_t)));
         write_pa(pi);
      end
      if (take_bits(2) == 32'd0) begin
         pg   = new_page(s);              // Absent from the set
         kind = EXP_MISS;
      end else begin
         pg = m_page[b][r];
         if (!m_valid[b][r]) begin
            kind = EXP_MISS;
         end else if ((acc == ACC_WRITE) ? m_wr[b][r] : m_rd[b][r]) begin
            kind = EXP_HIT;
         end else begin
            kind = EXP_PROT;
         end
      end
      run_request({pg, low}, acc, kind, {m_pa[pi], low});
   endtask

   // Hit, then miss once invalid, then hit on a new physical page
   task automatic revalid_case();
      bank_t    b;
      row_idx_t r;
      pa_idx_t  pi;
      va_t      addr;
      access_e  acc;
      b    = bank_t'(take_bits(`TLB_BANK_BITS));
      r    = row_idx_t'(take_bits(`TLB_ROW_BITS));
      pi   = {r, b};
      acc  = (take_bits(1) == 32'd1) ? ACC_WRITE : ACC_READ;
      addr = {m_page[b][r], in_page_t'(take_bits(`TLB_PAGE_BITS))};
      m_valid[b][r] = 1'b1;
      m_rd[b][r]    = 1'b1;
      m_wr[b][r]    = 1'b1;
      write_va(b, r);
      run_request(addr, acc, EXP_HIT, {m_pa[pi], addr[`TLB_PAGE_BITS-1:0]});
      m_valid[b][r] = 1'b0;
      write_va(b, r);
      run_request(addr, acc, EXP_MISS, '0);
      m_valid[b][r] = 1'b1;
      m_pa[pi]      = ~m_pa[pi];
      write_va(b, r);
      write_pa(pi);
      run_request(addr, acc, EXP_HIT, {m_pa[pi], addr[`TLB_PAGE_BITS-1:0]});
   endtask

   initial begin
      lfsr_q     = 32'd85451;
      req_cnt    = 0;
      rst_ni     = 1'b0;
      l1_miss    = 1'b0;
      in_addr    = '0;
      rw_type    = ACC_READ;
      cfg_we     = 1'b0;
      cfg_waddr  = '0;
      cfg_wdata  = '0;
      trans_sent = 1'b0;
      for (int b = 0; b < `TLB_BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            m_page[b][r]  = '0;
            m_valid[b][r] = 1'b0;
            m_rd[b][r]    = 1'b0;
            m_wr[b][r]    = 1'b0;
         end
      end
      for (int p = 0; p < PA_ROWS; p++) begin
         m_pa[p] = '0;
      end

      repeat (2) @(posedge clk_i);   // Two reset cycles
      @(negedge clk_i);
      rst_ni = 1'b1;
      check_flag("l2_busy_o", l2_busy, 1'b0);
      check_flag("hit_l2_o", hit_l2, 1'b0);
      check_flag("miss_l2_o", miss_l2, 1'b0);
      check_flag("prot_l2_o", prot_l2, 1'b0);

      fill_tables();
      while (req_cnt < NUM_REQ) begin
         if (take_bits(3) == 32'd0) begin
            revalid_case();
         end else begin
            random_request();
         end
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+sim
logic/tlb_addr_pkg.sv
logic/tlb_ctrl_pkg.sv
logic/tlb_search_if.sv
logic/tlb_va_bank.sv
logic/tlb_search_ctrl.sv
logic/tlb_result.sv
logic/tlb_l2.sv
sim/tlb_l2_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the TLB testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tlb_l2_tb -Mdir "$OBJ" -o tlb_l2_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/tlb_l2_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
   echo "Simulation reported a failing check"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
   echo "Simulation ended without a pass report"
   exit 1
fi
exit 0
